/* tb.f */
+incdir+verification
source/rv32i_pkg.sv
source/alu.sv
source/forwarding_unit.sv
source/execute_stage.sv
source/retire_pipe.sv
source/execute_core.sv
verification/execute_core_tb.sv

/* verification/execute_model.svh */
`ifndef EXECUTE_MODEL_SVH
`define EXECUTE_MODEL_SVH

// Register file contents without the two packets in flight
rv32i_pkg::rv32i_word shadow_rf [32];
// Front is the packet in MEM/WB, back the one in EX/MEM
rv32i_pkg::ex_mem_t   pred_q [$];

function automatic rv32i_pkg::rv32i_word apply_alu_op(input rv32i_pkg::alu_ops op,
        input rv32i_pkg::rv32i_word a, input rv32i_pkg::rv32i_word b);
    case (op)
        rv32i_pkg::alu_add: return a + b;
        rv32i_pkg::alu_sll: return a << b[4:0];
        rv32i_pkg::alu_sra: return rv32i_pkg::rv32i_word'($signed(a) >>> b[4:0]);
        rv32i_pkg::alu_sub: return a - b;
        rv32i_pkg::alu_xor: return a ^ b;
        rv32i_pkg::alu_srl: return a >> b[4:0];
        rv32i_pkg::alu_or:  return a | b;
        default:            return a & b;
    endcase
endfunction

// Signed order falls back to the sign bits when they differ
function automatic bit is_less(input rv32i_pkg::rv32i_word a,
        input rv32i_pkg::rv32i_word b, input bit signed_cmp);
    if (signed_cmp && (a[31] != b[31])) begin
        return a[31];
    end
    return a < b;
endfunction

function automatic bit compare_values(input rv32i_pkg::branch_funct3_t op,
        input rv32i_pkg::rv32i_word a, input rv32i_pkg::rv32i_word b);
    case (op)
        rv32i_pkg::beq:  return a == b;
        rv32i_pkg::bne:  return a != b;
        rv32i_pkg::blt:  return is_less(a, b, 1'b1);
        rv32i_pkg::bge:  return !is_less(a, b, 1'b1);
        rv32i_pkg::bltu: return is_less(a, b, 1'b0);
        rv32i_pkg::bgeu: return !is_less(a, b, 1'b0);
        default:         return 1'b0;
    endcase
endfunction

function automatic rv32i_pkg::rv32i_word writeback_value(input rv32i_pkg::ex_mem_t e);
    case (e.ctrl.regfilemux_sel)
        rv32i_pkg::regfilemux_br_en:    return {31'h0, e.br_en};
        rv32i_pkg::regfilemux_u_imm:    return e.u_imm;
        rv32i_pkg::regfilemux_pc_plus4: return e.pc_plus4;
        default:                        return e.alu_out;
    endcase
endfunction

function automatic rv32i_pkg::wb_t writeback_packet(input rv32i_pkg::ex_mem_t e);
    rv32i_pkg::wb_t w;
    w.valid        = e.valid;
    w.rd           = e.rd;
    w.load_regfile = e.valid && e.ctrl.load_regfile;
    w.data         = writeback_value(e);
    return w;
endfunction

// EX/MEM first, then MEM/WB, never x0
function automatic rv32i_pkg::rv32i_word forward_operand(input logic [4:0] src,
        input rv32i_pkg::rv32i_word reg_data, input rv32i_pkg::ex_mem_t ex,
        input rv32i_pkg::wb_t wb);
    if (ex.valid && ex.ctrl.load_regfile && (ex.rd != 5'd0) && (ex.rd == src)) begin
        return writeback_value(ex);
    end
    if (wb.valid && wb.load_regfile && (wb.rd != 5'd0) && (wb.rd == src)) begin
        return wb.data;
    end
    return reg_data;
endfunction

function automatic rv32i_pkg::ex_mem_t execute_packet(input rv32i_pkg::id_ex_t p);
    rv32i_pkg::ex_mem_t e;
    rv32i_pkg::wb_t     wb;
    logic [31:0]        w;
    rv32i_pkg::rv32i_word a;
    rv32i_pkg::rv32i_word b;
    rv32i_pkg::rv32i_word op1;
    rv32i_pkg::rv32i_word op2;
    rv32i_pkg::rv32i_word i_imm;
    w     = p.instr;
    wb    = writeback_packet(pred_q[0]);
    a     = forward_operand(w[19:15], p.rs1_data, pred_q[1], wb);
    b     = forward_operand(w[24:20], p.rs2_data, pred_q[1], wb);
    i_imm = {{21{w[31]}}, w[30:20]};
    op1   = (p.ctrl.alumux1_sel == rv32i_pkg::alumux1_pc_out) ? p.pc : a;
    case (p.ctrl.alumux2_sel)
        rv32i_pkg::alumux2_u_imm:   op2 = {w[31:12], 12'h000};
        rv32i_pkg::alumux2_b_imm:   op2 = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        rv32i_pkg::alumux2_s_imm:   op2 = {{21{w[31]}}, w[30:25], w[11:7]};
        rv32i_pkg::alumux2_j_imm:   op2 = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        rv32i_pkg::alumux2_rs2_out: op2 = b;
        default:                    op2 = i_imm;
    endcase
    e.valid    = p.valid;
    e.pc       = p.pc;
    e.instr    = p.instr;
    e.ctrl     = p.ctrl;
    e.alu_out  = apply_alu_op(p.ctrl.aluop, op1, op2);
    e.br_en    = compare_values(p.ctrl.cmpop, a,
                     (p.ctrl.cmpmux_sel == rv32i_pkg::cmpmux_i_imm) ? i_imm : b);
    e.rs2_fwd  = b;
    e.u_imm    = {w[31:12], 12'h000};
    e.pc_plus4 = p.pc + 32'd4;
    e.rd       = w[11:7];
    return e;
endfunction

function automatic void clear_predictions();
    rv32i_pkg::ex_mem_t idle;
    idle = '0;
    pred_q.delete();
    pred_q.push_back(idle);
    pred_q.push_back(idle);
endfunction

// On each driven packet the MEM/WB packet retires into the register file
function automatic void issue_packet(input rv32i_pkg::id_ex_t p);
    rv32i_pkg::ex_mem_t e;
    rv32i_pkg::ex_mem_t retired;
    e       = execute_packet(p);
    retired = pred_q.pop_front();
    if (retired.valid && retired.ctrl.load_regfile && (retired.rd != 5'd0)) begin
        shadow_rf[retired.rd] = writeback_value(retired);
    end
    pred_q.push_back(e);
endfunction

`endif

/* verification/execute_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_core_tb;

    localparam int num_instr    = 2000;
    localparam int reset_cycles = 16;
    localparam int drain_limit  = 8;

    logic               clk;
    logic               rst;
    rv32i_pkg::id_ex_t  id_ex;
    rv32i_pkg::ex_mem_t ex_mem;
    rv32i_pkg::wb_t     wb;
    integer             seed = 5864;

    `include "execute_model.svh"

    execute_core dut0 (
        .clk_i    (clk),
        .rst_i    (rst),
        .id_ex_i  (id_ex),
        .ex_mem_o (ex_mem),
        .wb_o     (wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ************************************************************************
    // Failure reporting and compare tasks
    // ************************************************************************

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
            input logic [31:0] want);
        fail_run($sformatf("mismatch at %0t: %s is %h, expected %h", $time, field, got, want));
    endtask

    task automatic check_ex_mem(input rv32i_pkg::ex_mem_t got, input rv32i_pkg::ex_mem_t want);
        if (got.valid !== want.valid) begin
            report_mismatch("ex_mem_o.valid", 32'(got.valid), 32'(want.valid));
        end else if (want.valid) begin
            if (got.pc !== want.pc)
                report_mismatch("ex_mem_o.pc", got.pc, want.pc);
            else if (got.instr !== want.instr)
                report_mismatch("ex_mem_o.instr", got.instr, want.instr);
            else if (got.ctrl !== want.ctrl)
                report_mismatch("ex_mem_o.ctrl", 32'(got.ctrl), 32'(want.ctrl));
            else if (got.alu_out !== want.alu_out)
                report_mismatch("ex_mem_o.alu_out", got.alu_out, want.alu_out);
            else if (got.br_en !== want.br_en)
                report_mismatch("ex_mem_o.br_en", 32'(got.br_en), 32'(want.br_en));
            else if (got.rs2_fwd !== want.rs2_fwd)
                report_mismatch("ex_mem_o.rs2_fwd", got.rs2_fwd, want.rs2_fwd);
            else if (got.u_imm !== want.u_imm)
                report_mismatch("ex_mem_o.u_imm", got.u_imm, want.u_imm);
            else if (got.pc_plus4 !== want.pc_plus4)
                report_mismatch("ex_mem_o.pc_plus4", got.pc_plus4, want.pc_plus4);
            else if (got.rd !== want.rd)
                report_mismatch("ex_mem_o.rd", 32'(got.rd), 32'(want.rd));
        end
    endtask

    task automatic check_wb(input rv32i_pkg::wb_t got, input rv32i_pkg::wb_t want);
        if (got.valid !== want.valid)
            report_mismatch("wb_o.valid", 32'(got.valid), 32'(want.valid));
        else if (got.load_regfile !== want.load_regfile)
            report_mismatch("wb_o.load_regfile", 32'(got.load_regfile), 32'(want.load_regfile));
        else if (want.valid && (got.rd !== want.rd))
            report_mismatch("wb_o.rd", 32'(got.rd), 32'(want.rd));
        else if (want.valid && (got.data !== want.data))
            report_mismatch("wb_o.data", got.data, want.data);
    endtask

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    function automatic rv32i_pkg::branch_funct3_t pick_cmpop(input logic [3:0] v);
        case (v % 4'd6)
            4'd0:    return rv32i_pkg::beq;
            4'd1:    return rv32i_pkg::bne;
            4'd2:    return rv32i_pkg::blt;
            4'd3:    return rv32i_pkg::bge;
            4'd4:    return rv32i_pkg::bltu;
            default: return rv32i_pkg::bgeu;
        endcase
    endfunction

    task automatic draw_packet(input bit bubble, output rv32i_pkg::id_ex_t p);
        rv32i_pkg::rv32i_control_word c;
        logic [31:0] w;
        logic [31:0] r;
        int          kind;
        w    = $random(seed);
        r    = $random(seed);
        kind = int'(r[7:0] % 8'd9);
        c.aluop          = rv32i_pkg::alu_ops'(r[18:16]);
        c.cmpop          = pick_cmpop(r[23:20]);
        c.alumux1_sel    = rv32i_pkg::alumux1_rs1_out;
        c.alumux2_sel    = rv32i_pkg::alumux2_i_imm;
        c.cmpmux_sel     = rv32i_pkg::cmpmux_rs2_out;
        c.regfilemux_sel = rv32i_pkg::regfilemux_alu_out;
        c.load_regfile   = 1'b1;
        c.mem_read       = 1'b0;
        c.mem_write      = 1'b0;
        // slt-style kinds compare signed or unsigned by r[24]
        if (kind == 2 || kind == 5) begin
            c.regfilemux_sel = rv32i_pkg::regfilemux_br_en;
            if (r[24])
                c.cmpop = rv32i_pkg::blt;
            else
                c.cmpop = rv32i_pkg::bltu;
        end
        case (kind)
            0, 1, 2: begin
                w[6:0]        = rv32i_pkg::op_reg;
                c.alumux2_sel = rv32i_pkg::alumux2_rs2_out;
            end
            3, 4, 5: begin
                w[6:0] = rv32i_pkg::op_imm;
                if (c.aluop == rv32i_pkg::alu_sub)
                    c.aluop = rv32i_pkg::alu_add;
                if (kind == 5)
                    c.cmpmux_sel = rv32i_pkg::cmpmux_i_imm;
            end
            6: begin
                w[6:0]         = rv32i_pkg::op_br;
                w[14:12]       = c.cmpop;
                c.alumux1_sel  = rv32i_pkg::alumux1_pc_out;
                c.alumux2_sel  = rv32i_pkg::alumux2_b_imm;
                c.aluop        = rv32i_pkg::alu_add;
                c.load_regfile = 1'b0;
            end
            7: begin
                c.aluop = rv32i_pkg::alu_add;
                if (r[25]) begin
                    w[6:0]           = rv32i_pkg::op_lui;
                    c.regfilemux_sel = rv32i_pkg::regfilemux_u_imm;
                end else begin
                    w[6:0]        = rv32i_pkg::op_auipc;
                    c.alumux1_sel = rv32i_pkg::alumux1_pc_out;
                    c.alumux2_sel = rv32i_pkg::alumux2_u_imm;
                end
            end
            default: begin
                w[6:0]           = rv32i_pkg::op_jal;
                c.aluop          = rv32i_pkg::alu_add;
                c.alumux1_sel    = rv32i_pkg::alumux1_pc_out;
                c.alumux2_sel    = rv32i_pkg::alumux2_j_imm;
                c.regfilemux_sel = rv32i_pkg::regfilemux_pc_plus4;
            end
        endcase
        // Only x0..x3 so that hazards are frequent
        w[11:7] = {3'b000, r[27:26]};
        if (kind <= 6) begin
            w[19:15] = {3'b000, r[29:28]};
            w[24:20] = {3'b000, r[31:30]};
        end
        p.valid    = !bubble;
        p.pc       = $random(seed);
        p.pc[1:0]  = 2'b00;
        p.instr    = w;
        p.rs1_data = shadow_rf[w[19:15]];
        p.rs2_data = shadow_rf[w[24:20]];
        p.ctrl     = c;
    endtask

    // Check what the last edge produced, then drive the next packet
    task automatic run_cycle(input bit bubble);
        rv32i_pkg::id_ex_t pkt;
        @(posedge clk);
        #1;
        check_ex_mem(ex_mem, pred_q[1]);
        check_wb(wb, writeback_packet(pred_q[0]));
        #1;
        draw_packet(bubble, pkt);
        id_ex = pkt;
        issue_packet(pkt);
    endtask

    initial begin
        int cycles;
        int issued;
        logic [31:0] r;
        // Reset must keep this live packet out of both registers
        id_ex                   = '0;
        id_ex.valid             = 1'b1;
        id_ex.ctrl.load_regfile = 1'b1;
        rst                     = 1'b1;
        for (int i = 0; i < 32; i++) begin
            shadow_rf[i] = $random(seed);
        end
        shadow_rf[0] = '0;
        shadow_rf[1] = shadow_rf[1] | 32'h8000_0000;
        shadow_rf[2] = shadow_rf[2] & 32'h7fff_ffff;
        clear_predictions();

        cycles = 0;
        while (cycles < reset_cycles) begin
            @(posedge clk);
            cycles++;
        end
        #2 rst = 1'b0;
        id_ex = '0;

        if (ex_mem.valid !== 1'b0 || wb.valid !== 1'b0 || wb.load_regfile !== 1'b0)
            fail_run("outputs still show valid packets after reset");

        issued = 0;
        while (issued < num_instr) begin
            r = $random(seed);
            run_cycle(r[2:0] == 3'd0);
            if (r[2:0] != 3'd0)
                issued++;
        end

        cycles = 0;
        while ((ex_mem.valid !== 1'b0 || wb.valid !== 1'b0) && cycles < drain_limit) begin
            run_cycle(1'b1);
            cycles++;
        end
        if (ex_mem.valid !== 1'b0 || wb.valid !== 1'b0) begin
            fail_run("pipeline did not drain within the cycle limit");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule : execute_core_tb

`default_nettype wire

/* source/execute_core.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_core (
    input  logic               clk_i,
    input  logic               rst_i,
    input  rv32i_pkg::id_ex_t  id_ex_i,
    output rv32i_pkg::ex_mem_t ex_mem_o,
    output rv32i_pkg::wb_t     wb_o
);

    rv32i_pkg::forwardingmux_sel_t fwd_a;
    rv32i_pkg::forwardingmux_sel_t fwd_b;
    rv32i_pkg::ex_mem_t            ex_result;
    rv32i_pkg::rv32i_word          mem_fwd_data;

    // ************************************************************************
    // Execute, combinational
    // ************************************************************************

    forwarding_unit fwd0 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .id_ex_i  (id_ex_i),
        .ex_mem_i (ex_mem_o),
        .wb_i     (wb_o),
        .fwd_a_o  (fwd_a),
        .fwd_b_o  (fwd_b)
    );

    execute_stage stage0 (
        .id_ex_i        (id_ex_i),
        .fwd_a_i        (fwd_a),
        .fwd_b_i        (fwd_b),
        .mem_fwd_data_i (mem_fwd_data),
        .wb_i           (wb_o),
        .ex_result_o    (ex_result)
    );

    // ************************************************************************
    // EX/MEM and MEM/WB
    // ************************************************************************

    retire_pipe retire0 (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .ex_result_i    (ex_result),
        .ex_mem_o       (ex_mem_o),
        .mem_fwd_data_o (mem_fwd_data),
        .wb_o           (wb_o)
    );

endmodule : execute_core

`default_nettype wire

/* source/retire_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_pipe (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  rv32i_pkg::ex_mem_t   ex_result_i,
    output rv32i_pkg::ex_mem_t   ex_mem_o,
    output rv32i_pkg::rv32i_word mem_fwd_data_o,
    output rv32i_pkg::wb_t       wb_o
);

    rv32i_pkg::ex_mem_t   ex_mem_q;
    rv32i_pkg::wb_t       wb_q;
    rv32i_pkg::rv32i_word wb_value;

    // ************************************************************************
    // EX/MEM register
    // ************************************************************************

    always_ff @(posedge clk_i) begin
        ex_mem_q <= ex_result_i;
        if (rst_i) begin
            ex_mem_q.valid             <= 1'b0;
            ex_mem_q.ctrl.load_regfile <= 1'b0;
        end
    end

    // Write-back value of the instruction now in EX/MEM
    always_comb begin
        wb_value = ex_mem_q.alu_out;
        unique case (ex_mem_q.ctrl.regfilemux_sel)
            rv32i_pkg::regfilemux_alu_out: begin
                wb_value = ex_mem_q.alu_out;
            end
            rv32i_pkg::regfilemux_br_en: begin
                wb_value = {{(rv32i_pkg::xlen-1){1'b0}}, ex_mem_q.br_en};
            end
            rv32i_pkg::regfilemux_u_imm: begin
                wb_value = ex_mem_q.u_imm;
            end
            rv32i_pkg::regfilemux_pc_plus4: begin
                wb_value = ex_mem_q.pc_plus4;
            end
        endcase
    end

    // ************************************************************************
    // MEM/WB register
    // ************************************************************************

    always_ff @(posedge clk_i) begin
        wb_q.rd   <= ex_mem_q.rd;
        wb_q.data <= wb_value;
        if (rst_i) begin
            wb_q.valid        <= 1'b0;
            wb_q.load_regfile <= 1'b0;
        end else begin
            wb_q.valid        <= ex_mem_q.valid;
            // Bubbles never write the register file
            wb_q.load_regfile <= ex_mem_q.valid && ex_mem_q.ctrl.load_regfile;
        end
    end

    assign ex_mem_o       = ex_mem_q;
    assign mem_fwd_data_o = wb_value;
    assign wb_o           = wb_q;

    // One cycle from EX/MEM to MEM/WB, no slip
    assert property (@(posedge clk_i) disable iff (rst_i)
        wb_q.valid == $past(ex_mem_q.valid))
        else $error("MEM/WB valid does not follow EX/MEM valid");

endmodule : retire_pipe

`default_nettype wire

/* source/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  rv32i_pkg::id_ex_t             id_ex_i,
    input  rv32i_pkg::forwardingmux_sel_t fwd_a_i,
    input  rv32i_pkg::forwardingmux_sel_t fwd_b_i,
    input  rv32i_pkg::rv32i_word          mem_fwd_data_i,
    input  rv32i_pkg::wb_t                wb_i,
    output rv32i_pkg::ex_mem_t            ex_result_o
);

    rv32i_pkg::rv32i_imm_view_t iv;
    rv32i_pkg::rv32i_word i_imm;
    rv32i_pkg::rv32i_word s_imm;
    rv32i_pkg::rv32i_word b_imm;
    rv32i_pkg::rv32i_word u_imm;
    rv32i_pkg::rv32i_word j_imm;
    rv32i_pkg::rv32i_word fwd_a_data;
    rv32i_pkg::rv32i_word fwd_b_data;
    rv32i_pkg::rv32i_word alumux1_out;
    rv32i_pkg::rv32i_word alumux2_out;
    rv32i_pkg::rv32i_word cmp_b;
    rv32i_pkg::rv32i_word alu_out;
    logic br_en;

    // ************************************************************************
    // Immediates
    // ************************************************************************

    assign iv    = id_ex_i.instr.imm;
    assign i_imm = {{21{iv.sign}}, iv.f30_25, iv.f24_21, iv.f20};
    assign s_imm = {{21{iv.sign}}, iv.f30_25, iv.f11_8, iv.f7};
    assign b_imm = {{20{iv.sign}}, iv.f7, iv.f30_25, iv.f11_8, 1'b0};
    assign u_imm = {iv.sign, iv.f30_25, iv.f24_21, iv.f20, iv.f19_12, 12'h000};
    assign j_imm = {{12{iv.sign}}, iv.f19_12, iv.f20, iv.f30_25, iv.f24_21, 1'b0};

    // ************************************************************************
    // Operand muxes
    // ************************************************************************

    always_comb begin
        fwd_a_data = id_ex_i.rs1_data;
        case (fwd_a_i)
            rv32i_pkg::fwd_ex_mem: fwd_a_data = mem_fwd_data_i;
            rv32i_pkg::fwd_mem_wb: fwd_a_data = wb_i.data;
            default:               fwd_a_data = id_ex_i.rs1_data;
        endcase

        fwd_b_data = id_ex_i.rs2_data;
        case (fwd_b_i)
            rv32i_pkg::fwd_ex_mem: fwd_b_data = mem_fwd_data_i;
            rv32i_pkg::fwd_mem_wb: fwd_b_data = wb_i.data;
            default:               fwd_b_data = id_ex_i.rs2_data;
        endcase
    end

    always_comb begin
        alumux1_out = (id_ex_i.ctrl.alumux1_sel == rv32i_pkg::alumux1_pc_out) ?
                      id_ex_i.pc : fwd_a_data;

        case (id_ex_i.ctrl.alumux2_sel)
            rv32i_pkg::alumux2_u_imm:   alumux2_out = u_imm;
            rv32i_pkg::alumux2_b_imm:   alumux2_out = b_imm;
            rv32i_pkg::alumux2_s_imm:   alumux2_out = s_imm;
            rv32i_pkg::alumux2_j_imm:   alumux2_out = j_imm;
            rv32i_pkg::alumux2_rs2_out: alumux2_out = fwd_b_data;
            default:                    alumux2_out = i_imm;
        endcase
    end

    alu alu0 (
        .aluop_i (id_ex_i.ctrl.aluop),
        .a_i     (alumux1_out),
        .b_i     (alumux2_out),
        .f_o     (alu_out)
    );

    // Comparator, also used by slt and sltu
    always_comb begin
        cmp_b = (id_ex_i.ctrl.cmpmux_sel == rv32i_pkg::cmpmux_i_imm) ? i_imm : fwd_b_data;
        case (id_ex_i.ctrl.cmpop)
            rv32i_pkg::beq:  br_en = (fwd_a_data == cmp_b);
            rv32i_pkg::bne:  br_en = (fwd_a_data != cmp_b);
            rv32i_pkg::blt:  br_en = ($signed(fwd_a_data) < $signed(cmp_b));
            rv32i_pkg::bge:  br_en = ($signed(fwd_a_data) >= $signed(cmp_b));
            rv32i_pkg::bltu: br_en = (fwd_a_data < cmp_b);
            rv32i_pkg::bgeu: br_en = (fwd_a_data >= cmp_b);
            default:         br_en = 1'b0;
        endcase
    end

    always_comb begin
        ex_result_o.valid    = id_ex_i.valid;
        ex_result_o.pc       = id_ex_i.pc;
        ex_result_o.instr    = id_ex_i.instr;
        ex_result_o.ctrl     = id_ex_i.ctrl;
        ex_result_o.alu_out  = alu_out;
        ex_result_o.br_en    = br_en;
        ex_result_o.rs2_fwd  = fwd_b_data;
        ex_result_o.u_imm    = u_imm;
        ex_result_o.pc_plus4 = id_ex_i.pc + rv32i_pkg::pc_incr;
        ex_result_o.rd       = id_ex_i.instr.r.rd;
    end

    // Decode and forwarding selects stay inside their encodings
    always_comb begin
        if (id_ex_i.valid) begin
            assert final (id_ex_i.ctrl.alumux2_sel inside {rv32i_pkg::alumux2_i_imm,
                    rv32i_pkg::alumux2_u_imm, rv32i_pkg::alumux2_b_imm,
                    rv32i_pkg::alumux2_s_imm, rv32i_pkg::alumux2_j_imm,
                    rv32i_pkg::alumux2_rs2_out})
                else $error("alumux2_sel out of range");
            assert final (fwd_a_i != 2'b11 && fwd_b_i != 2'b11)
                else $error("forwarding select out of range");
        end
    end

endmodule : execute_stage

`default_nettype wire

/* source/forwarding_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  rv32i_pkg::id_ex_t             id_ex_i,
    input  rv32i_pkg::ex_mem_t            ex_mem_i,
    input  rv32i_pkg::wb_t                wb_i,
    output rv32i_pkg::forwardingmux_sel_t fwd_a_o,
    output rv32i_pkg::forwardingmux_sel_t fwd_b_o
);

    rv32i_pkg::rv32i_reg rs1;
    rv32i_pkg::rv32i_reg rs2;
    logic ex_mem_writes;
    logic wb_writes;

    assign rs1 = id_ex_i.instr.r.rs1;
    assign rs2 = id_ex_i.instr.r.rs2;

    // Only live register writes are candidates
    assign ex_mem_writes = ex_mem_i.valid && ex_mem_i.ctrl.load_regfile &&
                           (ex_mem_i.rd != rv32i_pkg::reg_zero);
    assign wb_writes     = wb_i.valid && wb_i.load_regfile &&
                           (wb_i.rd != rv32i_pkg::reg_zero);

    // Younger result in EX/MEM wins over MEM/WB
    function automatic rv32i_pkg::forwardingmux_sel_t pick_source(rv32i_pkg::rv32i_reg src);
        rv32i_pkg::forwardingmux_sel_t sel;
        sel = rv32i_pkg::fwd_id_ex;
        if (ex_mem_writes && (ex_mem_i.rd == src)) begin
            sel = rv32i_pkg::fwd_ex_mem;
        end else if (wb_writes && (wb_i.rd == src)) begin
            sel = rv32i_pkg::fwd_mem_wb;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_o = pick_source(rs1);
        fwd_b_o = pick_source(rs2);
    end

    // x0 always reads from ID/EX
    assert property (@(posedge clk_i) disable iff (rst_i)
        (rs1 == rv32i_pkg::reg_zero) |-> (fwd_a_o == rv32i_pkg::fwd_id_ex))
        else $error("x0 forwarded on operand a");

    assert property (@(posedge clk_i) disable iff (rst_i)
        (rs2 == rv32i_pkg::reg_zero) |-> (fwd_b_o == rv32i_pkg::fwd_id_ex))
        else $error("x0 forwarded on operand b");

endmodule : forwarding_unit

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  rv32i_pkg::alu_ops    aluop_i,
    input  rv32i_pkg::rv32i_word a_i,
    input  rv32i_pkg::rv32i_word b_i,
    output rv32i_pkg::rv32i_word f_o
);

    logic [rv32i_pkg::shamt_w-1:0] shamt;

    assign shamt = b_i[rv32i_pkg::shamt_w-1:0];

    always_comb begin
        f_o = a_i + b_i;
        unique case (aluop_i)
            rv32i_pkg::alu_add: begin
                f_o = a_i + b_i;
            end
            rv32i_pkg::alu_sll: begin
                f_o = a_i << shamt;
            end
            rv32i_pkg::alu_sra: begin
                f_o = rv32i_pkg::rv32i_word'($signed(a_i) >>> shamt);
            end
            rv32i_pkg::alu_sub: begin
                f_o = a_i - b_i;
            end
            rv32i_pkg::alu_xor: begin
                f_o = a_i ^ b_i;
            end
            rv32i_pkg::alu_srl: begin
                f_o = a_i >> shamt;
            end
            rv32i_pkg::alu_or: begin
                f_o = a_i | b_i;
            end
            rv32i_pkg::alu_and: begin
                f_o = a_i & b_i;
            end
        endcase
    end

endmodule : alu

`default_nettype wire

/* source/rv32i_pkg.sv */
`default_nettype none

package rv32i_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int shamt_w   = 5;

    typedef logic [xlen-1:0]      rv32i_word;
    typedef logic [reg_idx_w-1:0] rv32i_reg;

    localparam rv32i_word pc_incr  = 32'd4;
    localparam rv32i_reg  reg_zero = '0;

    // ************************************************************************
    // Encodings
    // ************************************************************************

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops;

    // Same values as the branch funct3 field
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'b000,
        alumux2_u_imm   = 3'b001,
        alumux2_b_imm   = 3'b010,
        alumux2_s_imm   = 3'b011,
        alumux2_j_imm   = 3'b100,
        alumux2_rs2_out = 3'b101
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        fwd_id_ex  = 2'b00,
        fwd_ex_mem = 2'b01,
        fwd_mem_wb = 2'b10
    } forwardingmux_sel_t;

    typedef enum logic [1:0] {
        regfilemux_alu_out  = 2'b00,
        regfilemux_br_en    = 2'b01,
        regfilemux_u_imm    = 2'b10,
        regfilemux_pc_plus4 = 2'b11
    } regfilemux_sel_t;

    // ************************************************************************
    // Control word, instruction views and stage packets
    // ************************************************************************

    typedef struct packed {
        alu_ops          aluop;
        branch_funct3_t  cmpop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        cmpmux_sel_t     cmpmux_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            load_regfile;
        logic            mem_read;
        logic            mem_write;
    } rv32i_control_word;

    typedef struct packed {
        logic [6:0]  funct7;
        rv32i_reg    rs2;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } rv32i_r_view_t;

    // Raw immediate bits, split where the formats cut the word
    typedef struct packed {
        logic        sign;
        logic [5:0]  f30_25;
        logic [3:0]  f24_21;
        logic        f20;
        logic [7:0]  f19_12;
        logic [3:0]  f11_8;
        logic        f7;
        rv32i_opcode opcode;
    } rv32i_imm_view_t;

    typedef union packed {
        rv32i_r_view_t   r;
        rv32i_imm_view_t imm;
    } rv32i_instr_u;

    typedef struct packed {
        logic              valid;
        rv32i_word         pc;
        rv32i_instr_u      instr;
        rv32i_word         rs1_data;
        rv32i_word         rs2_data;
        rv32i_control_word ctrl;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        rv32i_word         pc;
        rv32i_instr_u      instr;
        rv32i_control_word ctrl;
        rv32i_word         alu_out;
        logic              br_en;
        rv32i_word         rs2_fwd;
        rv32i_word         u_imm;
        rv32i_word         pc_plus4;
        rv32i_reg          rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        rv32i_reg  rd;
        logic      load_regfile;
        rv32i_word data;
    } wb_t;

endpackage : rv32i_pkg

`default_nettype wire
